//--- Makefile
# Verilator build and run for conv_loop_tb

obj_dir/Vconv_loop_tb: flist.f $(shell cat flist.f)
	verilator --binary --timing --assert -Wno-fatal --top-module conv_loop_tb -f flist.f

.PHONY: run clean

# Pass only when the testbench prints the pass line
run: obj_dir/Vconv_loop_tb
	@out="$$(./obj_dir/Vconv_loop_tb +verilator+error+limit+100)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '>>> PASS'

clean:
	rm -rf obj_dir

//--- common/conv_pkg.sv
package conv_pkg;

	////////////////////
	// Map geometry

	localparam int IMAGE_WIDTH = 4;
	localparam int IMAGE_SIZE  = IMAGE_WIDTH * IMAGE_WIDTH;
	localparam int CH_IN       = 4;
	localparam int CH_OUT      = 4;

	// One full map, channel innermost
	localparam int MAP_DEPTH   = IMAGE_SIZE * CH_IN;

	// Result buffering at the output
	localparam int FIFO_DEPTH  = 4;

	////////////////////
	// Datapath widths

	localparam int PXL_W  = 8;
	localparam int WGT_W  = 8;
	localparam int ACC_W  = 20;
	localparam int ADDR_W = $clog2(MAP_DEPTH);
	localparam int CIN_W  = $clog2(CH_IN);
	localparam int COUT_W = $clog2(CH_OUT);

	typedef logic signed [PXL_W-1:0] pxl_t;
	typedef logic signed [WGT_W-1:0] wgt_t;
	typedef logic signed [ACC_W-1:0] acc_t;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [CIN_W-1:0]  cin_t;
	typedef logic [COUT_W-1:0] cout_t;

	////////////////////
	// Loop buffer FSM

	// LOAD fills the RAM, REPLAY streams it once per output channel
	typedef enum logic [0:0] {
		LOAD   = 1'b0,
		REPLAY = 1'b1
	} buf_state_t;

endpackage

//--- flist.f
common/conv_pkg.sv
loop_buffer/fmap_ram.sv
loop_buffer/loop_buffer.sv
src/mac_engine.sv
src/out_fifo.sv
src/conv_loop_top.sv
testbench/conv_loop_chk.sv
testbench/conv_loop_tb.sv

//--- loop_buffer/fmap_ram.sv
`timescale 1ns/1ps

module fmap_ram (
	input  logic            clk,
	input  logic            ram_en,
	input  logic            ram_we,
	input  conv_pkg::addr_t ram_addr,
	input  conv_pkg::pxl_t  ram_wdata,
	output conv_pkg::pxl_t  ram_rdata
);

	// One feature map, pixel-major
	conv_pkg::pxl_t mem [conv_pkg::MAP_DEPTH];

	////////////////////
	// Single port access

	// Read-first port returns the old contents on a write
	always_ff @(posedge clk) begin
		if (ram_en) begin
			if (ram_we) begin
				mem[ram_addr] <= ram_wdata;
			end
			ram_rdata <= mem[ram_addr];
		end
	end

	// Output register keeps its value while ram_en is low

endmodule

//--- loop_buffer/loop_buffer.sv
`timescale 1ns/1ps

module loop_buffer (
	input  logic              clk,
	input  logic              reset,
	input  logic              in_valid,
	input  conv_pkg::pxl_t    in_data,
	output logic              in_ready,
	output logic              rep_valid,
	output conv_pkg::pxl_t    rep_data,
	output conv_pkg::cin_t    rep_cin,
	output conv_pkg::cout_t   rep_cout,
	input  logic              rep_ready
);

	conv_pkg::buf_state_t state;
	conv_pkg::addr_t      addr;
	conv_pkg::cout_t      rep_cnt;
	logic                 rd_done;

	logic in_fire;
	logic rd_issue;
	logic rd_move;
	logic rep_fire;
	logic last_addr;
	logic last_pass;

	// RAM port
	logic            ram_en;
	logic            ram_we;
	conv_pkg::addr_t ram_addr;
	conv_pkg::pxl_t  ram_wdata;
	conv_pkg::pxl_t  ram_rdata;

	// Tags of the read sitting in the RAM output register
	logic            rd_pend;
	conv_pkg::cin_t  pend_cin;
	conv_pkg::cout_t pend_cout;
	logic            pend_last;

	// Holding register in front of the MAC
	logic            hold_valid;
	conv_pkg::pxl_t  hold_data;
	conv_pkg::cin_t  hold_cin;
	conv_pkg::cout_t hold_cout;
	logic            hold_last;

	////////////////////
	// Handshakes

	assign in_ready  = (state == conv_pkg::LOAD);
	assign in_fire   = in_valid && in_ready;
	assign last_addr = (addr == conv_pkg::addr_t'(conv_pkg::MAP_DEPTH - 1));
	assign last_pass = (rep_cnt == conv_pkg::cout_t'(conv_pkg::CH_OUT - 1));
	assign rep_fire  = hold_valid && rep_ready;

	// RAM output moves on when the holding register is free or draining
	assign rd_move  = rd_pend && (!hold_valid || rep_ready);
	// New read only if the RAM output register gets emptied this cycle
	assign rd_issue = (state == conv_pkg::REPLAY) && !rd_done && (!rd_pend || rd_move);

	assign ram_en    = in_fire || rd_issue;
	assign ram_we    = in_fire;
	assign ram_addr  = addr;
	assign ram_wdata = in_data;

	fmap_ram u_fmap_ram (
		.clk       (clk),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	////////////////////
	// Control FSM

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= conv_pkg::LOAD;
			addr    <= '0;
			rep_cnt <= '0;
			rd_done <= 1'b0;
		end else begin
			case (state)
				conv_pkg::LOAD: begin
					if (in_fire) begin
						addr <= last_addr ? '0 : addr + 1'b1;
						if (last_addr) begin
							state <= conv_pkg::REPLAY;
						end
					end
				end
				conv_pkg::REPLAY: begin
					if (rd_issue) begin
						if (last_addr) begin
							// End of one sweep, next output channel
							addr    <= '0;
							rep_cnt <= rep_cnt + 1'b1;
							rd_done <= last_pass;
						end else begin
							addr <= addr + 1'b1;
						end
					end
					// Back to loading once the final value has left
					if (rep_fire && hold_last) begin
						state   <= conv_pkg::LOAD;
						rep_cnt <= '0;
						rd_done <= 1'b0;
					end
				end
				default: state <= conv_pkg::LOAD;
			endcase
		end
	end

	////////////////////
	// Read pipeline

	always_ff @(posedge clk) begin
		if (reset) begin
			rd_pend    <= 1'b0;
			hold_valid <= 1'b0;
		end else begin
			if (rd_issue) begin
				rd_pend <= 1'b1;
			end else if (rd_move) begin
				rd_pend <= 1'b0;
			end
			if (rd_move) begin
				hold_valid <= 1'b1;
			end else if (rep_fire) begin
				hold_valid <= 1'b0;
			end
		end
	end

	// Tags travel alongside the read data
	always_ff @(posedge clk) begin
		if (rd_issue) begin
			pend_cin  <= addr[conv_pkg::CIN_W-1:0];
			pend_cout <= rep_cnt;
			pend_last <= last_addr && last_pass;
		end
		if (rd_move) begin
			hold_data <= ram_rdata;
			hold_cin  <= pend_cin;
			hold_cout <= pend_cout;
			hold_last <= pend_last;
		end
	end

	assign rep_valid = hold_valid;
	assign rep_data  = hold_data;
	assign rep_cin   = hold_cin;
	assign rep_cout  = hold_cout;

endmodule

//--- src/conv_loop_top.sv
`timescale 1ns/1ps

module conv_loop_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           in_valid,
	input  conv_pkg::pxl_t in_data,
	output logic           in_ready,
	output logic           out_valid,
	output conv_pkg::acc_t out_data,
	input  logic           out_ready
);

	// Replay stream
	logic            rep_valid;
	conv_pkg::pxl_t  rep_data;
	conv_pkg::cin_t  rep_cin;
	conv_pkg::cout_t rep_cout;
	logic            rep_ready;

	// Per-pixel sums
	logic            mac_valid;
	conv_pkg::acc_t  mac_data;
	logic            mac_ready;

	////////////////////
	// Input side

	loop_buffer u_loop_buffer (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.rep_valid (rep_valid),
		.rep_data  (rep_data),
		.rep_cin   (rep_cin),
		.rep_cout  (rep_cout),
		.rep_ready (rep_ready)
	);

	////////////////////
	// Processing

	mac_engine u_mac_engine (
		.clk       (clk),
		.reset     (reset),
		.rep_valid (rep_valid),
		.rep_data  (rep_data),
		.rep_cin   (rep_cin),
		.rep_cout  (rep_cout),
		.rep_ready (rep_ready),
		.mac_valid (mac_valid),
		.mac_data  (mac_data),
		.mac_ready (mac_ready)
	);

	////////////////////
	// Output side

	out_fifo u_out_fifo (
		.clk      (clk),
		.reset    (reset),
		.wr_valid (mac_valid),
		.wr_data  (mac_data),
		.wr_ready (mac_ready),
		.rd_valid (out_valid),
		.rd_data  (out_data),
		.rd_ready (out_ready)
	);

endmodule

//--- src/mac_engine.sv
`timescale 1ns/1ps

module mac_engine (
	input  logic            clk,
	input  logic            reset,
	input  logic            rep_valid,
	input  conv_pkg::pxl_t  rep_data,
	input  conv_pkg::cin_t  rep_cin,
	input  conv_pkg::cout_t rep_cout,
	output logic            rep_ready,
	output logic            mac_valid,
	output conv_pkg::acc_t  mac_data,
	input  logic            mac_ready
);

	// Output-channel-major weight table
	conv_pkg::wgt_t weights [conv_pkg::CH_OUT * conv_pkg::CH_IN];

	logic [conv_pkg::COUT_W+conv_pkg::CIN_W-1:0] wgt_idx;
	conv_pkg::wgt_t wgt;
	conv_pkg::acc_t product;
	conv_pkg::acc_t acc;
	conv_pkg::acc_t acc_base;
	conv_pkg::acc_t acc_next;
	logic           rep_fire;
	logic           last_cin;

	initial begin
		$readmemh("weights.hex", weights);
	end

	////////////////////
	// Multiply

	assign wgt_idx = {rep_cout, rep_cin};
	assign wgt     = weights[wgt_idx];

	// Both operands sign-extended to the accumulator width
	assign product = conv_pkg::acc_t'(rep_data) * conv_pkg::acc_t'(wgt);

	// Channel zero starts a new pixel
	assign acc_base = (rep_cin == '0) ? '0 : acc;
	assign acc_next = acc_base + product;

	////////////////////
	// Accumulate

	// Stall only when a finished sum is still waiting
	assign rep_ready = !mac_valid || mac_ready;
	assign rep_fire  = rep_valid && rep_ready;
	assign last_cin  = (rep_cin == conv_pkg::cin_t'(conv_pkg::CH_IN - 1));

	always_ff @(posedge clk) begin
		if (rep_fire) begin
			acc <= acc_next;
		end
		if (rep_fire && last_cin) begin
			mac_data <= acc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			mac_valid <= 1'b0;
		end else if (rep_fire && last_cin) begin
			mac_valid <= 1'b1;
		end else if (mac_ready) begin
			mac_valid <= 1'b0;
		end
	end

endmodule

//--- src/out_fifo.sv
`timescale 1ns/1ps

module out_fifo (
	input  logic           clk,
	input  logic           reset,
	input  logic           wr_valid,
	input  conv_pkg::acc_t wr_data,
	output logic           wr_ready,
	output logic           rd_valid,
	output conv_pkg::acc_t rd_data,
	input  logic           rd_ready
);

	conv_pkg::acc_t mem [conv_pkg::FIFO_DEPTH];

	logic [$clog2(conv_pkg::FIFO_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(conv_pkg::FIFO_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(conv_pkg::FIFO_DEPTH+1)-1:0] count;
	logic full;
	logic wr_fire;
	logic rd_fire;

	assign full     = (count == conv_pkg::FIFO_DEPTH);
	assign rd_valid = (count != '0);
	assign rd_data  = mem[rd_ptr];

	// A full FIFO still takes a write when the head leaves this cycle
	assign wr_ready = !full || rd_ready;
	assign wr_fire  = wr_valid && wr_ready;
	assign rd_fire  = rd_valid && rd_ready;

	////////////////////
	// Storage

	always_ff @(posedge clk) begin
		if (wr_fire) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	////////////////////
	// Pointers

	// Depth is a power of two, pointers wrap on their own
	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_fire) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_fire) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			if (wr_fire && !rd_fire) begin
				count <= count + 1'b1;
			end else if (rd_fire && !wr_fire) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

//--- testbench/conv_loop_chk.sv
`timescale 1ns/1ps

module conv_loop_chk (
	input logic           clk,
	input logic           reset,
	input logic           in_ready,
	input logic           ram_we,
	input logic           rd_pend,
	input logic           rep_valid,
	input logic           rep_ready,
	input conv_pkg::pxl_t rep_data
);

	int assert_fails;

	initial begin
		assert_fails = 0;
	end

	////////////////////
	// Replay handshake

	// Stalled value stays put until the MAC takes it
	stall_hold: assert property (
		@(posedge clk) disable iff (reset)
		rep_valid && !rep_ready |=> rep_valid && $stable(rep_data)
	) else begin
		$error("rep_valid or rep_data changed while rep_ready was low");
		assert_fails++;
	end

	////////////////////
	// Buffer state

	// Loading stays closed while replayed data is still held
	no_load_in_replay: assert property (
		@(posedge clk) disable iff (reset)
		rep_valid |-> !in_ready
	) else begin
		$error("in_ready high while replay data was still held");
		assert_fails++;
	end

	// A write would overwrite a read still waiting in the RAM output register
	no_write_in_replay: assert property (
		@(posedge clk) disable iff (reset)
		ram_we |-> !rd_pend
	) else begin
		$error("RAM write while a replay read was pending");
		assert_fails++;
	end

endmodule

bind loop_buffer conv_loop_chk u_chk (
	.clk       (clk),
	.reset     (reset),
	.in_ready  (in_ready),
	.ram_we    (ram_we),
	.rd_pend   (rd_pend),
	.rep_valid (rep_valid),
	.rep_ready (rep_ready),
	.rep_data  (rep_data)
);

//--- testbench/conv_loop_tb.sv
`timescale 1ns/1ps

module conv_loop_tb;

	localparam int RES_PER_MAP = conv_pkg::CH_OUT * conv_pkg::IMAGE_SIZE;
	localparam int PAT_LEN     = 256;
	localparam int TIMEOUT     = 1000;

	logic           clk;
	logic           reset;
	logic           in_valid;
	conv_pkg::pxl_t in_data;
	logic           in_ready;
	logic           out_valid;
	conv_pkg::acc_t out_data;
	logic           out_ready;

	integer         seed;
	conv_pkg::wgt_t wgt_mem [conv_pkg::CH_OUT * conv_pkg::CH_IN];
	conv_pkg::pxl_t send_q [$];
	conv_pkg::acc_t exp_q [$];
	bit             valid_pat [PAT_LEN];
	bit             ready_pat [PAT_LEN];

	int accept_cnt;
	int out_cnt;
	int test_err;
	int err_total;
	int test_cnt;
	int fail_cnt;
	int asserts;
	bit timed_out;

	conv_loop_top UUT (
		.clk       (clk),
		.reset     (reset),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_data  (out_data),
		.out_ready (out_ready)
	);

	initial clk = 1'b0;
	always #4 clk = ~clk;

	// Results that have left the DUT
	always @(posedge clk) begin
		if (reset) begin
			out_cnt <= 0;
		end else if (out_valid && out_ready) begin
			out_cnt <= out_cnt + 1;
		end
	end

	////////////////////
	// Reference model

	// kind 1 is all -128, kind 2 all +127, anything else random
	task automatic add_map(input int kind);
		conv_pkg::pxl_t pix [conv_pkg::MAP_DEPTH];
		int sum;
		int i;
		int o;
		int p;
		int c;
		for (i = 0; i < conv_pkg::MAP_DEPTH; i++) begin
			case (kind)
				1: pix[i] = conv_pkg::pxl_t'(-128);
				2: pix[i] = conv_pkg::pxl_t'(127);
				default: pix[i] = conv_pkg::pxl_t'($random(seed));
			endcase
			send_q.push_back(pix[i]);
		end
		// Output channel outer, pixel inner
		for (o = 0; o < conv_pkg::CH_OUT; o++) begin
			for (p = 0; p < conv_pkg::IMAGE_SIZE; p++) begin
				sum = 0;
				for (c = 0; c < conv_pkg::CH_IN; c++) begin
					sum += int'(wgt_mem[o * conv_pkg::CH_IN + c])
						* int'(pix[p * conv_pkg::CH_IN + c]);
				end
				exp_q.push_back(conv_pkg::acc_t'(sum));
			end
		end
	endtask

	task automatic make_patterns(input int valid_pct, input int ready_pct);
		int i;
		for (i = 0; i < PAT_LEN; i++) begin
			valid_pat[i] = ($unsigned($random(seed)) % 100) < valid_pct;
			ready_pat[i] = ($unsigned($random(seed)) % 100) < ready_pct;
		end
	endtask

	////////////////////
	// Stream drivers

	// Previous map must have fully left the loop buffer before new data goes in
	task automatic check_accept(input string name);
		int map_idx;
		int produced;
		map_idx  = accept_cnt / conv_pkg::MAP_DEPTH;
		produced = out_cnt + int'(UUT.u_out_fifo.count) + int'(UUT.mac_valid);
		if (map_idx > 0 && produced < map_idx * RES_PER_MAP) begin
			$display("%s: input accepted while %0d results of the previous map were pending",
				name, map_idx * RES_PER_MAP - produced);
			test_err++;
		end
	endtask

	task automatic drive_inputs(input string name);
		int cyc;
		int idle;
		cyc  = 0;
		idle = 0;
		while (send_q.size() > 0 && !timed_out) begin
			@(negedge clk);
			in_valid = valid_pat[cyc % PAT_LEN];
			in_data  = send_q[0];
			cyc++;
			if (in_valid && in_ready) begin
				check_accept(name);
				send_q.delete(0);
				accept_cnt++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT) begin
					$display("%s: timed out waiting for in_ready, %0d values left to send",
						name, send_q.size());
					test_err++;
					timed_out = 1'b1;
				end
			end
		end
		@(negedge clk);
		in_valid = 1'b0;
	endtask

	task automatic collect_results(input string name, input int n);
		conv_pkg::acc_t exp;
		int got;
		int cyc;
		int idle;
		got  = 0;
		cyc  = 0;
		idle = 0;
		while (got < n && !timed_out) begin
			@(negedge clk);
			out_ready = ready_pat[cyc % PAT_LEN];
			cyc++;
			if (out_valid && out_ready) begin
				exp = exp_q.pop_front();
				if (out_data !== exp) begin
					$display("[ERROR] %s: result %0d expected %0d, got %0d",
						name, got, exp, out_data);
					test_err++;
				end
				got++;
				idle = 0;
			end else begin
				idle++;
				if (idle > TIMEOUT) begin
					$display("%s: timed out waiting for result %0d of %0d", name, got, n);
					test_err++;
					timed_out = 1'b1;
				end
			end
		end
	endtask

	// Nothing left over, ready for the next map
	task automatic expect_idle(input string name);
		int i;
		out_ready = 1'b1;
		for (i = 0; i < 8; i++) begin
			@(negedge clk);
			if (out_valid) begin
				$display("%s: extra result %0d after the last expected one", name, out_data);
				test_err++;
			end
		end
		if (in_ready !== 1'b1) begin
			$display("[ERROR] %s: in_ready expected 1, got %b", name, in_ready);
			test_err++;
		end
	endtask

	task automatic finish_test(input string name, input int n);
		test_cnt++;
		err_total += test_err;
		if (test_err == 0) begin
			$display("test %s done, %0d results, ok", name, n);
		end else begin
			fail_cnt++;
			$display("test %s done, %0d results, %0d errors", name, n, test_err);
		end
	endtask

	task automatic run_traffic(input string name, input int valid_pct, input int ready_pct);
		int n;
		n        = exp_q.size();
		test_err = 0;
		make_patterns(valid_pct, ready_pct);
		fork
			drive_inputs(name);
			collect_results(name, n);
		join
		if (!timed_out) begin
			expect_idle(name);
		end
		finish_test(name, n);
	endtask

	////////////////////
	// Test sequence

	initial begin
		seed       = 39298;
		reset      = 1'b1;
		in_valid   = 1'b0;
		in_data    = '0;
		out_ready  = 1'b0;
		accept_cnt = 0;
		test_err   = 0;
		err_total  = 0;
		test_cnt   = 0;
		fail_cnt   = 0;
		timed_out  = 1'b0;
		$readmemh("weights.hex", wgt_mem);

		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		@(negedge clk);
		if (in_ready !== 1'b1) begin
			$display("[ERROR] reset_state: in_ready expected 1, got %b", in_ready);
			test_err++;
		end
		if (out_valid !== 1'b0) begin
			$display("[ERROR] reset_state: out_valid expected 0, got %b", out_valid);
			test_err++;
		end
		finish_test("reset_state", 0);

		add_map(0);
		run_traffic("single_map", 100, 100);
		if (!timed_out) begin
			add_map(0);
			run_traffic("input_gaps", 60, 100);
		end
		if (!timed_out) begin
			add_map(0);
			run_traffic("output_stall", 100, 40);
		end
		// Second map waits on the first one's drain
		if (!timed_out) begin
			add_map(0);
			add_map(0);
			run_traffic("load_block", 90, 40);
		end
		if (!timed_out) begin
			add_map(1);
			add_map(2);
			add_map(0);
			run_traffic("extreme_maps", 100, 70);
		end

		asserts = UUT.u_loop_buffer.u_chk.assert_fails;
		$display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
			test_cnt, fail_cnt, err_total, asserts);
		if (fail_cnt == 0 && asserts == 0 && !timed_out) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

//--- weights.hex
// One signed 8-bit weight per line, line o*CH_IN+c holds weight(o,c)
03
fe
7f
80
11
f5
00
2a
81
19
e7
05
40
c3
0c
f9
